// ==== verilog/pipePkg.sv ====
package pipePkg;

	localparam int DATA_W = 32;
	localparam int REG_W = 5;
	localparam int REG_NUM = 1 << REG_W;

	// Instruction fields
	localparam int OP_HI = 31;
	localparam int OP_LO = 26;
	localparam int RS_LO = 21;
	localparam int RT_LO = 16;
	localparam int RD_LO = 11;
	localparam int IMM_W = 16;

	localparam int DMEM_WORDS = 16;
	localparam int DMEM_AW = 4; // Word index from byte address bits 5:2

	localparam logic [DATA_W-1:0] RESET_PC = '0;

	typedef enum logic [OP_HI-OP_LO:0] {
		OP_NOP  = 6'h00,
		OP_ADD  = 6'h01,
		OP_SUB  = 6'h02,
		OP_BEQ  = 6'h04,
		OP_ADDI = 6'h08,
		OP_LW   = 6'h23,
		OP_SW   = 6'h2b
	} opcodeT;

	typedef enum logic [1:0] {
		FWD_NONE  = 2'b00,
		FWD_EXMEM = 2'b01,
		FWD_MEMWB = 2'b10
	} fwdSelT;

endpackage

// ==== verilog/stageTagIf.sv ====
`timescale 1ns/10ps

interface stageTagIf;
	import pipePkg::*;

	logic rfWr;
	logic dmRd;
	logic [REG_W-1:0] dest;
	logic [DATA_W-1:0] result;

	modport producer (
		output rfWr,
		output dmRd,
		output dest,
		output result
	);

	modport consumer (
		input rfWr,
		input dmRd,
		input dest,
		input result
	);

endinterface

// ==== verilog/regFile.sv ====
`timescale 1ns/10ps

module regFile (
	input logic clk,
	input logic rst_sign,
	input logic [pipePkg::REG_W-1:0] rdAddrA,
	input logic [pipePkg::REG_W-1:0] rdAddrB,
	output logic [pipePkg::DATA_W-1:0] rdDataA,
	output logic [pipePkg::DATA_W-1:0] rdDataB,
	input logic wrEn,
	input logic [pipePkg::REG_W-1:0] wrAddr,
	input logic [pipePkg::DATA_W-1:0] wrData
);
	import pipePkg::*;

	logic [DATA_W-1:0] regs [REG_NUM];
	logic wrLive;

	assign wrLive = wrEn && (wrAddr != '0); // r0 stays zero

	always_ff @(posedge clk) begin
		if (rst_sign) begin
			for (int i = 0; i < REG_NUM; i++)
				regs[i] <= '0;
		end else if (wrLive) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Write-through so decode sees the value retiring this cycle
	assign rdDataA = (wrLive && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
	assign rdDataB = (wrLive && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

// ==== verilog/aluUnit.sv ====
`timescale 1ns/10ps

module aluUnit (
	input pipePkg::opcodeT op,
	input logic [pipePkg::DATA_W-1:0] srcA,
	input logic [pipePkg::DATA_W-1:0] srcB,
	output logic [pipePkg::DATA_W-1:0] result
);
	import pipePkg::*;

	logic isSub;
	logic [DATA_W-1:0] addB;
	logic [DATA_W-1:0] sum;

	assign isSub = (op == OP_SUB);
	assign addB = isSub ? ~srcB : srcB;

	// One adder for arithmetic and address generation
	assign sum = srcA + addB + {{(DATA_W-1){1'b0}}, isSub};

	always_comb begin
		case (op)
			OP_ADD, OP_ADDI, OP_LW, OP_SW, OP_SUB: begin
				result = sum;
			end
			OP_BEQ: begin
				result = {{(DATA_W-1){1'b0}}, srcA == srcB}; // Equality flag
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

// ==== verilog/bypassUnit.sv ====
`timescale 1ns/10ps

module bypassUnit (
	input logic [pipePkg::REG_W-1:0] idExRs,
	input logic [pipePkg::REG_W-1:0] idExRt,
	input logic [pipePkg::REG_W-1:0] ifIdRs,
	input logic [pipePkg::REG_W-1:0] ifIdRt,
	input logic isBranch,
	stageTagIf.consumer exMem,
	stageTagIf.consumer memWb,
	output pipePkg::fwdSelT fwdA,
	output pipePkg::fwdSelT fwdB,
	output logic brFwdA,
	output logic brFwdB
);
	import pipePkg::*;

	function automatic logic tagHit(
		input logic rfWr,
		input logic [REG_W-1:0] dest,
		input logic [REG_W-1:0] src
	);
		return rfWr && (dest != '0) && (dest == src);
	endfunction

	// Youngest producer wins
	function automatic fwdSelT pickFwd(input logic [REG_W-1:0] src);
		if (tagHit(exMem.rfWr, exMem.dest, src))
			return FWD_EXMEM;
		else if (tagHit(memWb.rfWr, memWb.dest, src))
			return FWD_MEMWB;
		else
			return FWD_NONE;
	endfunction

	always_comb begin
		fwdA = pickFwd(idExRs);
		fwdB = pickFwd(idExRt);
	end

	// MEM/WB case handled by register file write-through
	assign brFwdA = isBranch && tagHit(exMem.rfWr, exMem.dest, ifIdRs);
	assign brFwdB = isBranch && tagHit(exMem.rfWr, exMem.dest, ifIdRt);

endmodule

// ==== verilog/stallUnit.sv ====
`timescale 1ns/10ps

module stallUnit (
	input logic rst_sign,
	input logic [pipePkg::REG_W-1:0] ifIdRs,
	input logic [pipePkg::REG_W-1:0] ifIdRt,
	input logic isBranch,
	input logic idExRfWr,
	input logic idExDmRd,
	input logic [pipePkg::REG_W-1:0] idExDest,
	stageTagIf.consumer exMem,
	output logic pcWr,
	output logic ifIdWr,
	output logic bubbleSel,
	output logic instEn
);
	import pipePkg::*;

	logic loadUse;
	logic brOnEx;
	logic brOnLoad;
	logic stall;

	function automatic logic srcHit(input logic [REG_W-1:0] dest);
		return (dest != '0) && ((dest == ifIdRs) || (dest == ifIdRt));
	endfunction

	assign loadUse = idExDmRd && srcHit(idExDest);
	assign brOnEx = isBranch && idExRfWr && srcHit(idExDest); // Compare operand not ready yet
	assign brOnLoad = isBranch && exMem.dmRd && srcHit(exMem.dest);
	assign stall = loadUse || brOnEx || brOnLoad;

	always_comb begin
		if (rst_sign) begin
			pcWr = 1'b0;
			ifIdWr = 1'b0;
			instEn = 1'b0;
			bubbleSel = 1'b1;
		end else begin
			pcWr = !stall;
			ifIdWr = !stall;
			instEn = !stall;
			bubbleSel = stall;
		end
	end

endmodule

// ==== verilog/dataMem.sv ====
`timescale 1ns/10ps

module dataMem (
	input logic clk,
	input logic rst_sign,
	input logic wrEn,
	input logic [pipePkg::DMEM_AW-1:0] addr,
	input logic [pipePkg::DATA_W-1:0] wrData,
	output logic [pipePkg::DATA_W-1:0] rdData
);
	import pipePkg::*;

	logic [DATA_W-1:0] mem [DMEM_WORDS];

	always_ff @(posedge clk) begin
		if (rst_sign) begin
			for (int i = 0; i < DMEM_WORDS; i++)
				mem[i] <= '0;
		end else if (wrEn) begin
			mem[addr] <= wrData;
		end
	end

	assign rdData = mem[addr]; // Async read

endmodule

// ==== verilog/cpuTop.sv ====
`timescale 1ns/10ps

module cpuTop (
	input logic clk,
	input logic rst_sign,
	output logic instEn,
	output logic [pipePkg::DATA_W-1:0] instAddr,
	input logic [pipePkg::DATA_W-1:0] instData,
	output logic wbEn,
	output logic [pipePkg::REG_W-1:0] wbReg,
	output logic [pipePkg::DATA_W-1:0] wbData
);
	import pipePkg::*;

	logic [DATA_W-1:0] pc;
	logic pcWr, ifIdWr, bubbleSel;

	logic [DATA_W-1:0] ifIdInst, ifIdPc4;
	opcodeT idOp;
	logic [REG_W-1:0] ifIdRs, ifIdRt, ifIdRd, idDest;
	logic [DATA_W-1:0] idImm, rfA, rfB, brA, brB, brTarget;
	logic idRfWr, idDmRd, idDmWr, isBranch, brTaken, brFwdA, brFwdB;

	opcodeT idExOp;
	logic idExRfWr, idExDmRd, idExDmWr;
	logic [REG_W-1:0] idExRs, idExRt, idExDest;
	logic [DATA_W-1:0] idExA, idExB, idExImm;

	fwdSelT fwdA, fwdB;
	logic [DATA_W-1:0] exOpA, exOpB, aluB, aluOut;

	logic exMemRfWr, exMemDmRd, exMemDmWr;
	logic [REG_W-1:0] exMemDest;
	logic [DATA_W-1:0] exMemAlu, exMemStore, dmRdData;

	logic memWbRfWr, memWbDmRd;
	logic [REG_W-1:0] memWbDest;
	logic [DATA_W-1:0] memWbAlu, memWbLoad;

	stageTagIf exMemTag();
	stageTagIf memWbTag();

	function automatic logic [DATA_W-1:0] fwdMux(input fwdSelT sel, input logic [DATA_W-1:0] regVal);
		case (sel)
			FWD_EXMEM: return exMemTag.result;
			FWD_MEMWB: return memWbTag.result;
			default: return regVal;
		endcase
	endfunction

	assign instAddr = pc;

	always_ff @(posedge clk) begin
		if (rst_sign)
			pc <= RESET_PC;
		else if (pcWr)
			pc <= brTaken ? brTarget : pc + DATA_W'(4); // Delay slot is already in fetch
	end

	always_ff @(posedge clk) begin
		if (rst_sign) begin
			ifIdInst <= '0;
			ifIdPc4 <= '0;
		end else if (ifIdWr) begin
			ifIdInst <= instData;
			ifIdPc4 <= pc + DATA_W'(4);
		end
	end

	assign idOp = opcodeT'(ifIdInst[OP_HI:OP_LO]);
	assign ifIdRs = ifIdInst[RS_LO +: REG_W];
	assign ifIdRt = ifIdInst[RT_LO +: REG_W];
	assign ifIdRd = ifIdInst[RD_LO +: REG_W];
	assign idImm = {{(DATA_W-IMM_W){ifIdInst[IMM_W-1]}}, ifIdInst[IMM_W-1:0]};

	always_comb begin
		idRfWr = 1'b0;
		idDmRd = 1'b0;
		idDmWr = 1'b0;
		idDest = '0;
		case (idOp)
			OP_ADD, OP_SUB: begin
				idRfWr = 1'b1;
				idDest = ifIdRd;
			end
			OP_ADDI: begin
				idRfWr = 1'b1;
				idDest = ifIdRt;
			end
			OP_LW: begin
				idRfWr = 1'b1;
				idDmRd = 1'b1;
				idDest = ifIdRt;
			end
			OP_SW: idDmWr = 1'b1;
			default: ;
		endcase
	end

	// Branch resolves in decode
	assign isBranch = (idOp == OP_BEQ);
	assign brA = brFwdA ? exMemTag.result : rfA;
	assign brB = brFwdB ? exMemTag.result : rfB;
	assign brTaken = isBranch && (brA == brB);
	assign brTarget = ifIdPc4 + {idImm[DATA_W-3:0], 2'b00};

	regFile rf (
		.clk(clk), .rst_sign(rst_sign),
		.rdAddrA(ifIdRs), .rdAddrB(ifIdRt), .rdDataA(rfA), .rdDataB(rfB),
		.wrEn(memWbRfWr), .wrAddr(memWbDest), .wrData(memWbTag.result)
	);

	stallUnit stall (
		.rst_sign(rst_sign), .ifIdRs(ifIdRs), .ifIdRt(ifIdRt), .isBranch(isBranch),
		.idExRfWr(idExRfWr), .idExDmRd(idExDmRd), .idExDest(idExDest),
		.exMem(exMemTag.consumer),
		.pcWr(pcWr), .ifIdWr(ifIdWr), .bubbleSel(bubbleSel), .instEn(instEn)
	);

	bypassUnit bypass (
		.idExRs(idExRs), .idExRt(idExRt), .ifIdRs(ifIdRs), .ifIdRt(ifIdRt),
		.isBranch(isBranch), .exMem(exMemTag.consumer), .memWb(memWbTag.consumer),
		.fwdA(fwdA), .fwdB(fwdB), .brFwdA(brFwdA), .brFwdB(brFwdB)
	);

	always_ff @(posedge clk) begin
		if (rst_sign || bubbleSel) begin
			idExOp <= OP_NOP; // Bubble
			idExRfWr <= 1'b0;
			idExDmRd <= 1'b0;
			idExDmWr <= 1'b0;
			idExDest <= '0;
		end else begin
			idExOp <= idOp;
			idExRfWr <= idRfWr;
			idExDmRd <= idDmRd;
			idExDmWr <= idDmWr;
			idExDest <= idDest;
		end
	end

	always_ff @(posedge clk) begin
		idExRs <= ifIdRs;
		idExRt <= ifIdRt;
		idExA <= rfA;
		idExB <= rfB;
		idExImm <= idImm;
	end

	assign exOpA = fwdMux(fwdA, idExA);
	assign exOpB = fwdMux(fwdB, idExB); // Also the store data
	assign aluB = (idExOp inside {OP_ADDI, OP_LW, OP_SW}) ? idExImm : exOpB;

	aluUnit alu (.op(idExOp), .srcA(exOpA), .srcB(aluB), .result(aluOut));

	always_ff @(posedge clk) begin
		if (rst_sign) begin
			exMemRfWr <= 1'b0;
			exMemDmRd <= 1'b0;
			exMemDmWr <= 1'b0;
			exMemDest <= '0;
		end else begin
			exMemRfWr <= idExRfWr;
			exMemDmRd <= idExDmRd;
			exMemDmWr <= idExDmWr;
			exMemDest <= idExDest;
		end
		exMemAlu <= aluOut;
		exMemStore <= exOpB;
	end

	assign exMemTag.rfWr = exMemRfWr;
	assign exMemTag.dmRd = exMemDmRd;
	assign exMemTag.dest = exMemDest;
	assign exMemTag.result = exMemAlu;

	dataMem dmem (
		.clk(clk), .rst_sign(rst_sign), .wrEn(exMemDmWr),
		.addr(exMemAlu[DMEM_AW+1:2]), .wrData(exMemStore), .rdData(dmRdData)
	);

	always_ff @(posedge clk) begin
		if (rst_sign) begin
			memWbRfWr <= 1'b0;
			memWbDmRd <= 1'b0;
			memWbDest <= '0;
		end else begin
			memWbRfWr <= exMemRfWr;
			memWbDmRd <= exMemDmRd;
			memWbDest <= exMemDest;
		end
		memWbAlu <= exMemAlu;
		memWbLoad <= dmRdData;
	end

	assign memWbTag.rfWr = memWbRfWr;
	assign memWbTag.dmRd = memWbDmRd;
	assign memWbTag.dest = memWbDest;
	assign memWbTag.result = memWbTag.dmRd ? memWbLoad : memWbAlu;

	assign wbEn = memWbRfWr && (memWbDest != '0);
	assign wbReg = memWbDest;
	assign wbData = memWbTag.result;

endmodule

// ==== bench/clockGen.sv ====
`timescale 1ns/10ps

module clockGen (
	output logic clk,
	output logic rst_sign
);

	initial begin
		clk = 1'b0;
		rst_sign = 1'b1;
		repeat (4) @(posedge clk);
		#1 rst_sign = 1'b0; // Released just after the 4th edge
	end

	always #10 clk = ~clk; // 20 ns period

endmodule

// ==== bench/cpuChecker.sv ====
`timescale 1ns/10ps

module cpuChecker (
	input logic clk,
	input logic rst_sign,
	input logic instEn,
	input logic [pipePkg::DATA_W-1:0] instAddr,
	input logic wbEn,
	input logic [pipePkg::REG_W-1:0] wbReg,
	input logic [pipePkg::DATA_W-1:0] wbData
);

	wbKnown: assert property (@(posedge clk) wbEn |-> !$isunknown({wbReg, wbData}))
		else $error("writeback report carries unknown bits");

	quietInReset: assert property (@(posedge clk)
		(rst_sign && $past(rst_sign)) |-> (!instEn && !wbEn))
		else $error("fetch or writeback active during reset");

	// Stall keeps the fetch address
	fetchAddrHeld: assert property (@(posedge clk) (!rst_sign && !instEn) |=> $stable(instAddr))
		else $error("fetch address moved during a stall");

endmodule

bind cpuTop cpuChecker chk (
	.clk(clk), .rst_sign(rst_sign), .instEn(instEn), .instAddr(instAddr),
	.wbEn(wbEn), .wbReg(wbReg), .wbData(wbData)
);

// ==== bench/isaModel.svh ====
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

localparam int PROG_LEN = 200;

logic [DATA_W-1:0] prog [PROG_LEN];
logic [REG_W-1:0] expReg [$];
logic [DATA_W-1:0] expData [$];

function automatic logic [DATA_W-1:0] encode(input opcodeT op, input logic [REG_W-1:0] rs,
	input logic [REG_W-1:0] rt, input logic [REG_W-1:0] rd, input logic [IMM_W-1:0] imm);
	if (op == OP_ADD || op == OP_SUB)
		return {op, rs, rt, rd, 11'b0}; // R-type
	return {op, rs, rt, imm};
endfunction

// Runs the program in order, one delay slot after each branch
task automatic runModel();
	logic [DATA_W-1:0] rf [REG_NUM];
	logic [DATA_W-1:0] dm [DMEM_WORDS];
	logic [DATA_W-1:0] inst, a, b, imm, addr, wrVal;
	logic [REG_W-1:0] rt, rd, wrReg;
	int pc, nextPc, target;
	bit pending;
	for (int i = 0; i < REG_NUM; i++)
		rf[i] = '0;
	for (int i = 0; i < DMEM_WORDS; i++)
		dm[i] = '0;
	pc = 0;
	target = 0;
	pending = 1'b0;
	while (pc < PROG_LEN) begin
		inst = prog[pc];
		nextPc = pending ? target : pc + 1; // Delay slot done, redirect now
		pending = 1'b0;
		rt = inst[RT_LO +: REG_W];
		rd = inst[RD_LO +: REG_W];
		a = rf[inst[RS_LO +: REG_W]];
		b = rf[rt];
		imm = {{(DATA_W-IMM_W){inst[IMM_W-1]}}, inst[IMM_W-1:0]};
		addr = a + imm;
		wrReg = '0;
		wrVal = '0;
		case (opcodeT'(inst[OP_HI:OP_LO]))
			OP_ADD: begin
				wrReg = rd;
				wrVal = a + b;
			end
			OP_SUB: begin
				wrReg = rd;
				wrVal = a - b;
			end
			OP_ADDI: begin
				wrReg = rt;
				wrVal = addr;
			end
			OP_LW: begin
				wrReg = rt;
				wrVal = dm[addr[DMEM_AW+1:2]];
			end
			OP_SW: dm[addr[DMEM_AW+1:2]] = b;
			OP_BEQ: begin
				pending = (a == b);
				target = pc + 1 + int'($signed(inst[IMM_W-1:0])); // Relative to the slot
			end
			default: ;
		endcase
		if (wrReg != '0) begin
			rf[wrReg] = wrVal;
			expReg.push_back(wrReg);
			expData.push_back(wrVal);
		end
		pc = nextPc;
	end
endtask

`endif

// ==== bench/cpuBench.sv ====
`timescale 1ns/10ps

module cpuBench;
	import pipePkg::*;

	localparam int TAIL_NOPS = 8;
	localparam int FETCH_TIMEOUT = 20;
	localparam int RUN_TIMEOUT = 4000;
	localparam int IDLE_CYCLES = 40;

	logic clk, rst_sign, instEn, wbEn;
	logic [DATA_W-1:0] instAddr, instData, wbData;
	logic [REG_W-1:0] wbReg;
	int cyc, fetchCyc, wbCount;
	bit fetchSeen;

	`include "isaModel.svh"

	clockGen clkGen (.clk(clk), .rst_sign(rst_sign));

	cpuTop UUT (
		.clk(clk), .rst_sign(rst_sign), .instEn(instEn), .instAddr(instAddr),
		.instData(instData), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData)
	);

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic checkEq(input string name, input logic [DATA_W-1:0] expv,
		input logic [DATA_W-1:0] actv);
		if (actv !== expv)
			abortRun($sformatf("ERR %0t %s expected %h actual %h", $time, name, expv, actv));
	endtask

	function automatic logic [REG_W-1:0] randReg();
		return REG_W'($urandom_range(7, 0)); // Small pool forces hazards
	endfunction

	function automatic logic [DATA_W-1:0] fetchWord(input logic [DATA_W-1:0] addr);
		int idx;
		idx = int'(addr >> 2);
		if (idx < PROG_LEN)
			return prog[idx];
		return '0; // NOP past the end
	endfunction

	task automatic genProgram();
		logic [REG_W-1:0] rs, rt;
		logic [IMM_W-1:0] imm;
		opcodeT op;
		bit lastBranch;
		lastBranch = 1'b0;
		prog[0] = encode(OP_ADDI, '0, 5'd1, '0, 16'd5); // Fixed first ADDI for latency
		for (int i = 1; i < PROG_LEN - TAIL_NOPS; i++) begin
			rs = randReg();
			rt = randReg();
			imm = IMM_W'($urandom_range(40, 0)) - 16'd20;
			case ($urandom_range(9, 0))
				0, 1: op = OP_ADD;
				2: op = OP_SUB;
				3, 4: op = OP_ADDI;
				5, 6: op = OP_LW;
				7: op = OP_SW;
				default: op = lastBranch ? OP_ADDI : OP_BEQ; // No branch in a delay slot
			endcase
			if (op inside {OP_LW, OP_SW}) begin
				if ($urandom_range(1, 0) == 0)
					rs = '0; // Plain word addresses so stores meet loads
				imm = IMM_W'($urandom_range(15, 0) * 4);
			end
			if (op == OP_BEQ) begin
				if ($urandom_range(1, 0) == 0)
					rt = rs; // Always taken
				imm = IMM_W'($urandom_range(4, 1));
			end
			prog[i] = encode(op, rs, rt, randReg(), imm);
			lastBranch = (op == OP_BEQ);
		end
		for (int i = PROG_LEN - TAIL_NOPS; i < PROG_LEN; i++)
			prog[i] = '0;
	endtask

	always @(posedge clk) begin
		#1;
		instData = fetchWord(instAddr);
	end

	// Mid-cycle sampling of the DUT outputs
	always @(negedge clk) begin
		cyc++;
		if (rst_sign) begin
			checkEq("instEn", '0, 32'(instEn));
			checkEq("wbEn", '0, 32'(wbEn));
		end else begin
			if (!fetchSeen) begin
				checkEq("instEn", 32'd1, 32'(instEn));
				checkEq("instAddr", RESET_PC, instAddr);
				fetchSeen = 1'b1;
				fetchCyc = cyc;
			end
			if (wbEn) begin
				if (wbCount >= expReg.size())
					abortRun("DUT wrote back more results than the model expects");
				if (wbCount == 0)
					checkEq("wbLatency", 32'd4, 32'(cyc - fetchCyc));
				checkEq("wbReg", 32'(expReg[wbCount]), 32'(wbReg));
				checkEq("wbData", expData[wbCount], wbData);
				wbCount++;
			end
		end
	end

	initial begin
		int waited;
		instData = '0;
		cyc = 0;
		fetchCyc = 0;
		wbCount = 0;
		fetchSeen = 1'b0;
		void'($urandom(32'h6d10));
		genProgram();
		runModel();
		waited = 0;
		while (!fetchSeen) begin
			@(posedge clk);
			waited++;
			if (waited > FETCH_TIMEOUT)
				abortRun("no fetch seen after reset was released");
		end
		waited = 0;
		while (wbCount < expReg.size()) begin
			@(posedge clk);
			waited++;
			if (waited > RUN_TIMEOUT)
				abortRun("timed out waiting for the expected writebacks");
		end
		waited = 0;
		while (waited < IDLE_CYCLES) begin
			@(posedge clk);
			waited++; // Late extra writebacks hit the monitor
		end
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+bench
verilog/pipePkg.sv
verilog/stageTagIf.sv
verilog/regFile.sv
verilog/aluUnit.sv
verilog/bypassUnit.sv
verilog/stallUnit.sv
verilog/dataMem.sv
verilog/cpuTop.sv
bench/clockGen.sv
bench/cpuChecker.sv
bench/cpuBench.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpuBench -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

simOut=$(./obj_dir/VcpuBench)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
